/* vlog.f */
rtl/pipePkg.sv
rtl/instrDecode.sv
rtl/regFile.sv
rtl/fwdUnit.sv
rtl/regIdEx.sv
rtl/execStage.sv
rtl/decExecTop.sv
testbench/decExec_checker.sv
testbench/decExecTb.sv

/* run.sh */
#!/bin/sh
# Builds the decode/execute testbench with Verilator, runs it and looks for the pass line.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module decExecTb -o decExecSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/decExecSim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qF '*** TEST PASSED ***'; then
    exit 0
fi
echo "Pass line not found in simulation output"
exit 1

/* testbench/decExec_testdata.txt */
// Columns in hex: instruction, stall cycles before issue, expected WbReg (00 = no write),
// expected WbData. The instruction ffffffff ends the stream.
20010005 0 01 00000005 // addi  r1, r0, 5
2402fffd 0 02 fffffffd // addiu r2, r0, -3
34038001 0 03 00008001 // ori   r3, r0, 0x8001
3c041234 0 04 12340000 // lui   r4, 0x1234
00222820 0 05 00000002 // add   r5, r1, r2
00a13022 0 06 fffffffd // sub   r6, r5, r1   forwarded on rs
00663824 0 07 00008001 // and   r7, r3, r6   forwarded on rt
00e74025 0 08 00008001 // or    r8, r7, r7   forwarded on both
00874826 0 09 12348001 // xor   r9, r4, r7   register file write-through
01205027 0 0a edcb7ffe // nor   r10, r9, r0
0041582a 0 0b 00000001 // slt   r11, r2, r1
0041602b 0 0c 00000000 // sltu  r12, r2, r1
00036900 0 0d 00080010 // sll   r13, r3, 4
00027202 0 0e 00ffffff // srl   r14, r2, 8
00027a03 0 0f ffffffff // sra   r15, r2, 8
00838021 0 10 12348001 // addu  r16, r4, r3
00228823 0 11 00000008 // subu  r17, r1, r2
3052ff0f 0 12 0000ff0d // andi  r18, r2, 0xff0f
3833ffff 0 13 0000fffa // xori  r19, r1, 0xffff
2854fffe 0 14 00000001 // slti  r20, r2, -2
2c35ffff 0 15 00000001 // sltiu r21, r1, -1
22b67fff 2 16 00008000 // addi  r22, r21, 0x7fff after two stalls
02d6b820 1 17 00010000 // add   r23, r22, r22 after one stall
20200007 0 00 00000000 // addi  r0, r1, 7
0001c020 0 18 00000005 // add   r24, r0, r1
00840025 0 00 00000000 // or    r0, r4, r4
0003c821 0 19 00008001 // addu  r25, r0, r3
0019d0c0 3 1a 00040008 // sll   r26, r25, 3 after three stalls
001ad883 0 1b 00010002 // sra   r27, r26, 2
3c1c8000 0 1c 80000000 // lui   r28, 0x8000
001ce903 0 1d f8000000 // sra   r29, r28, 4
001cf7c2 0 1e 00000001 // srl   r30, r28, 31
ffffffff 0 00 00000000

/* testbench/decExecTb.sv */
`timescale 1ns/1ps

module decExecTb;

    logic                             Clk;
    logic                             Reset;
    logic                             InstrValid;
    logic [pipePkg::dataWidth-1:0]    Instr;
    logic                             Stall;
    logic                             WbValid;
    logic [pipePkg::regAddrWidth-1:0] WbReg;
    logic [pipePkg::dataWidth-1:0]    WbData;

    logic [31:0]                      testMem [0:255]; // Four words per data line.
    int                               testIdQ [$];
    logic [pipePkg::regAddrWidth-1:0] expRegQ [$];
    logic [pipePkg::dataWidth-1:0]    expDataQ [$];
    int numTests = 0;
    int totalStalls = 0;
    int expWrites = 0;
    int wbSeen = 0;
    int testsPassed = 0;
    int testsFailed = 0;
    int errorCount = 0;
    int cycleCount = 0;
    int cycleLimit = 0;

    decExecTop u_decExecTop (
        .Clk(Clk), .Reset(Reset), .InstrValid(InstrValid), .Instr(Instr), .Stall(Stall),
        .WbValid(WbValid), .WbReg(WbReg), .WbData(WbData)
    );

    initial begin
        Clk = 1'b0;
        forever #4 Clk = ~Clk;
    end

    task automatic checkEqual(input string what, input logic [31:0] got,
                              input logic [31:0] expected);
        if (got !== expected) begin
            $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, expected);
            errorCount++;
        end
    endtask

    task automatic reportTest(input int id, input bit ok);
        if (ok) begin
            testsPassed++;
            $display("Test %0d: ok", id);
        end else begin
            testsFailed++;
            $display("Test %0d: wrong write-back", id);
        end
    endtask

    // Instructions that write nothing retire when a later write-back arrives.
    task automatic retireNoWrites();
        while (expRegQ.size() > 0 && expRegQ[0] == '0) begin
            void'(expRegQ.pop_front());
            void'(expDataQ.pop_front());
            reportTest(testIdQ.pop_front(), 1'b1);
        end
    endtask

    // Stall cycles hold the same word on Instr before it is accepted.
    task automatic issueInstr(input logic [31:0] word, input int stalls);
        repeat (stalls) begin
            @(posedge Clk);
            Instr      <= word;
            InstrValid <= 1'b1;
            Stall      <= 1'b1;
        end
        @(posedge Clk);
        Instr      <= word;
        InstrValid <= 1'b1;
        Stall      <= 1'b0;
    endtask

    initial begin
        Reset      <= 1'b0;
        InstrValid <= 1'b0;
        Instr      <= '0;
        Stall      <= 1'b0;
        $readmemh("testbench/decExec_testdata.txt", testMem);
        while (numTests < $size(testMem) / 4 && testMem[4*numTests] != 32'hffff_ffff) begin
            totalStalls += testMem[4*numTests+1];
            if (testMem[4*numTests+2][4:0] != '0) expWrites++;
            numTests++;
        end
        cycleLimit = numTests + totalStalls + 20;
        repeat (5) @(posedge Clk);
        Reset <= 1'b1;
        for (int i = 0; i < numTests; i++) begin
            issueInstr(testMem[4*i], testMem[4*i+1]);
            testIdQ.push_back(i + 1);
            expRegQ.push_back(testMem[4*i+2][4:0]);
            expDataQ.push_back(testMem[4*i+3]);
        end
        @(posedge Clk);
        InstrValid <= 1'b0;
        while (wbSeen < expWrites) @(posedge Clk);
        repeat (4) @(posedge Clk); // Leaves room for a stray write-back to show up.
        retireNoWrites();
        $display("Tests: %0d passed, %0d failed; write-backs %0d of %0d; errors %0d",
                 testsPassed, testsFailed, wbSeen, expWrites, errorCount);
        if (numTests > 0 && errorCount == 0 && testsPassed == numTests) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // Write-back outputs change on the rising edge and are sampled half a cycle later.
    always @(negedge Clk) begin : wbMonitor
        int errBefore;
        int id;
        if (Reset && WbValid) begin
            retireNoWrites();
            if (expRegQ.size() == 0) begin
                $display("Unexpected write-back to r%0d at %0t ns with nothing left to retire",
                         WbReg, $time);
                errorCount++;
            end else begin
                errBefore = errorCount;
                id = testIdQ.pop_front();
                checkEqual($sformatf("test %0d WbReg", id), 32'(WbReg), 32'(expRegQ.pop_front()));
                checkEqual($sformatf("test %0d WbData", id), WbData, expDataQ.pop_front());
                reportTest(id, errorCount == errBefore);
                wbSeen++;
            end
        end
    end

    always @(posedge Clk) begin
        if (Reset) begin
            cycleCount <= cycleCount + 1;
        end
        if (cycleLimit > 0 && cycleCount > cycleLimit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

endmodule

/* testbench/decExec_checker.sv */
`timescale 1ns/1ps

module decExecChecker (
    input logic                             Clk,
    input logic                             Reset,
    input logic                             Stall,
    input logic                             InstrValid,
    input logic                             ERegWrite,
    input logic                             WbValid,
    input logic [pipePkg::regAddrWidth-1:0] WbReg
);

    resetQuiet: assert property (@(posedge Clk) !Reset |-> !WbValid)
        else $error("WbValid is high while Reset is asserted");

    noZeroWrite: assert property (@(posedge Clk) disable iff (!Reset) WbValid |-> (WbReg != '0))
        else $error("Write-back targets register zero");

    // A stalled or empty issue slot leaves a bubble in the ID/EX register.
    stallBubble: assert property (@(posedge Clk) disable iff (!Reset) Stall |=> !ERegWrite)
        else $error("ERegWrite is high after a stall cycle");

    idleBubble: assert property (@(posedge Clk) disable iff (!Reset) !InstrValid |=> !ERegWrite)
        else $error("ERegWrite is high after a cycle with no valid instruction");

endmodule

bind decExecTop decExecChecker u_decExecChecker (
    .Clk(Clk), .Reset(Reset), .Stall(Stall), .InstrValid(InstrValid),
    .ERegWrite(eRegWrite), .WbValid(WbValid), .WbReg(WbReg)
);

/* rtl/decExecTop.sv */
`timescale 1ns/1ps

module decExecTop (
    input  logic                             Clk,
    input  logic                             Reset,
    input  logic                             InstrValid,
    input  logic [pipePkg::dataWidth-1:0]    Instr,
    input  logic                             Stall,
    output logic                             WbValid,
    output logic [pipePkg::regAddrWidth-1:0] WbReg,
    output logic [pipePkg::dataWidth-1:0]    WbData
);

    logic [pipePkg::regAddrWidth-1:0] rs, rt, writeReg;
    logic [pipePkg::dataWidth-1:0]    sa, imm32, qa, qb;
    logic [pipePkg::aluOpWidth-1:0]   aluControl;
    logic                             aluXSrc, aluYSrc, useUnsigned, regWrite;
    logic [pipePkg::fwdWidth-1:0]     fwdA, fwdB;

    logic [pipePkg::dataWidth-1:0]    eQa, eQb, eExt32, eSa;
    logic [pipePkg::regAddrWidth-1:0] eWriteReg;
    logic [pipePkg::aluOpWidth-1:0]   eAluControl;
    logic                             eAluXSrc, eAluYSrc, eUnsigned, eRegWrite;
    logic [pipePkg::fwdWidth-1:0]     eFwdA, eFwdB;

    instrDecode u_instrDecode (
        .Instr(Instr), .Rs(rs), .Rt(rt), .WriteReg(writeReg), .Sa(sa), .Imm32(imm32),
        .AluControl(aluControl), .AluXSrc(aluXSrc), .AluYSrc(aluYSrc),
        .Unsigned(useUnsigned), .RegWrite(regWrite)
    );

    // The write port is fed straight from the EX/WB register.
    regFile u_regFile (
        .Clk(Clk), .Reset(Reset), .RdAddrA(rs), .RdAddrB(rt), .QA(qa), .QB(qb),
        .WrEn(WbValid), .WrAddr(WbReg), .WrData(WbData)
    );

    fwdUnit u_fwdUnit (
        .Rs(rs), .Rt(rt), .ExWriteReg(eWriteReg), .ExRegWrite(eRegWrite),
        .FwdA(fwdA), .FwdB(fwdB)
    );

    regIdEx u_regIdEx (
        .Clk(Clk), .Reset(Reset), .Stall(Stall), .Valid(InstrValid),
        .Qa(qa), .Qb(qb), .Ext32(imm32), .Sa(sa), .WriteReg(writeReg),
        .AluControl(aluControl), .AluXSrc(aluXSrc), .AluYSrc(aluYSrc),
        .Unsigned(useUnsigned), .RegWrite(regWrite), .FwdA(fwdA), .FwdB(fwdB),
        .EQa(eQa), .EQb(eQb), .EExt32(eExt32), .ESa(eSa), .EWriteReg(eWriteReg),
        .EAluControl(eAluControl), .EAluXSrc(eAluXSrc), .EAluYSrc(eAluYSrc),
        .EUnsigned(eUnsigned), .ERegWrite(eRegWrite), .EFwdA(eFwdA), .EFwdB(eFwdB)
    );

    execStage u_execStage (
        .Clk(Clk), .Reset(Reset), .EQa(eQa), .EQb(eQb), .EExt32(eExt32), .ESa(eSa),
        .EWriteReg(eWriteReg), .EAluControl(eAluControl), .EAluXSrc(eAluXSrc),
        .EAluYSrc(eAluYSrc), .EUnsigned(eUnsigned), .ERegWrite(eRegWrite),
        .EFwdA(eFwdA), .EFwdB(eFwdB),
        .WbValid(WbValid), .WbReg(WbReg), .WbData(WbData)
    );

endmodule

/* rtl/execStage.sv */
`timescale 1ns/1ps

module execStage (
    input  logic                             Clk,
    input  logic                             Reset,
    input  logic [pipePkg::dataWidth-1:0]    EQa,
    input  logic [pipePkg::dataWidth-1:0]    EQb,
    input  logic [pipePkg::dataWidth-1:0]    EExt32,
    input  logic [pipePkg::dataWidth-1:0]    ESa,
    input  logic [pipePkg::regAddrWidth-1:0] EWriteReg,
    input  logic [pipePkg::aluOpWidth-1:0]   EAluControl,
    input  logic                             EAluXSrc,
    input  logic                             EAluYSrc,
    input  logic                             EUnsigned,
    input  logic                             ERegWrite,
    input  logic [pipePkg::fwdWidth-1:0]     EFwdA,
    input  logic [pipePkg::fwdWidth-1:0]     EFwdB,
    output logic                             WbValid,
    output logic [pipePkg::regAddrWidth-1:0] WbReg,
    output logic [pipePkg::dataWidth-1:0]    WbData
);

    logic [pipePkg::dataWidth-1:0] opA;
    logic [pipePkg::dataWidth-1:0] opB;
    logic [pipePkg::dataWidth-1:0] aluX;
    logic [pipePkg::dataWidth-1:0] aluY;
    logic [pipePkg::dataWidth:0]   diff;
    logic [pipePkg::dataWidth-1:0] result;
    logic [4:0]                    shamt;

    assign opA = (EFwdA == pipePkg::fwdWb) ? WbData : EQa;
    assign opB = (EFwdB == pipePkg::fwdWb) ? WbData : EQb;

    assign aluX  = EAluXSrc ? ESa : opA; // Shifts take the amount on X.
    assign aluY  = EAluYSrc ? EExt32 : opB;
    assign shamt = aluX[4:0];

    // One extra bit makes the borrow the less-than flag, signed or not.
    assign diff = {~EUnsigned & aluX[pipePkg::dataWidth-1], aluX}
                - {~EUnsigned & aluY[pipePkg::dataWidth-1], aluY};

    always_comb begin
        case (EAluControl)
            pipePkg::aluSub:  result = aluX - aluY;
            pipePkg::aluAnd:  result = aluX & aluY;
            pipePkg::aluOr:   result = aluX | aluY;
            pipePkg::aluXor:  result = aluX ^ aluY;
            pipePkg::aluNor:  result = ~(aluX | aluY);
            pipePkg::aluSlt,
            pipePkg::aluSltu: result = {{(pipePkg::dataWidth-1){1'b0}}, diff[pipePkg::dataWidth]};
            pipePkg::aluSll:  result = aluY << shamt;
            pipePkg::aluSrl:  result = aluY >> shamt;
            pipePkg::aluSra:  result = $signed(aluY) >>> shamt;
            pipePkg::aluLui:  result = {aluY[15:0], 16'h0000};
            default:          result = aluX + aluY;
        endcase
    end

    always_ff @(posedge Clk or negedge Reset) begin
        if (!Reset) begin
            WbValid <= 1'b0;
            WbReg   <= '0;
            WbData  <= '0;
        end else begin
            WbValid <= ERegWrite && (EWriteReg != '0); // No write-back to register zero.
            WbReg   <= EWriteReg;
            WbData  <= result;
        end
    end

endmodule

/* rtl/regIdEx.sv */
`timescale 1ns/1ps

module regIdEx (
    input  logic                             Clk,
    input  logic                             Reset,
    input  logic                             Stall,
    input  logic                             Valid,
    input  logic [pipePkg::dataWidth-1:0]    Qa,
    input  logic [pipePkg::dataWidth-1:0]    Qb,
    input  logic [pipePkg::dataWidth-1:0]    Ext32,
    input  logic [pipePkg::dataWidth-1:0]    Sa,
    input  logic [pipePkg::regAddrWidth-1:0] WriteReg,
    input  logic [pipePkg::aluOpWidth-1:0]   AluControl,
    input  logic                             AluXSrc,
    input  logic                             AluYSrc,
    input  logic                             Unsigned,
    input  logic                             RegWrite,
    input  logic [pipePkg::fwdWidth-1:0]     FwdA,
    input  logic [pipePkg::fwdWidth-1:0]     FwdB,
    output logic [pipePkg::dataWidth-1:0]    EQa,
    output logic [pipePkg::dataWidth-1:0]    EQb,
    output logic [pipePkg::dataWidth-1:0]    EExt32,
    output logic [pipePkg::dataWidth-1:0]    ESa,
    output logic [pipePkg::regAddrWidth-1:0] EWriteReg,
    output logic [pipePkg::aluOpWidth-1:0]   EAluControl,
    output logic                             EAluXSrc,
    output logic                             EAluYSrc,
    output logic                             EUnsigned,
    output logic                             ERegWrite,
    output logic [pipePkg::fwdWidth-1:0]     EFwdA,
    output logic [pipePkg::fwdWidth-1:0]     EFwdB
);

    logic bubble;

    assign bubble = Stall || !Valid;

    always_ff @(posedge Clk or negedge Reset) begin
        if (!Reset) begin
            EQa         <= '0;
            EQb         <= '0;
            EExt32      <= '0;
            ESa         <= '0;
            EWriteReg   <= '0;
            EAluControl <= '0;
            EAluXSrc    <= 1'b0;
            EAluYSrc    <= 1'b0;
            EUnsigned   <= 1'b0;
            ERegWrite   <= 1'b0;
            EFwdA       <= pipePkg::fwdNone;
            EFwdB       <= pipePkg::fwdNone;
        end else if (bubble) begin // A stalled or empty slot leaves an all-zero stage behind.
            EQa         <= '0;
            EQb         <= '0;
            EExt32      <= '0;
            ESa         <= '0;
            EWriteReg   <= '0;
            EAluControl <= '0;
            EAluXSrc    <= 1'b0;
            EAluYSrc    <= 1'b0;
            EUnsigned   <= 1'b0;
            ERegWrite   <= 1'b0;
            EFwdA       <= pipePkg::fwdNone;
            EFwdB       <= pipePkg::fwdNone;
        end else begin
            EQa         <= Qa;
            EQb         <= Qb;
            EExt32      <= Ext32;
            ESa         <= Sa;
            EWriteReg   <= WriteReg;
            EAluControl <= AluControl;
            EAluXSrc    <= AluXSrc;
            EAluYSrc    <= AluYSrc;
            EUnsigned   <= Unsigned;
            ERegWrite   <= RegWrite;
            EFwdA       <= FwdA;
            EFwdB       <= FwdB;
        end
    end

endmodule

/* rtl/fwdUnit.sv */
`timescale 1ns/1ps

module fwdUnit (
    input  logic [pipePkg::regAddrWidth-1:0] Rs,
    input  logic [pipePkg::regAddrWidth-1:0] Rt,
    input  logic [pipePkg::regAddrWidth-1:0] ExWriteReg,
    input  logic                             ExRegWrite,
    output logic [pipePkg::fwdWidth-1:0]     FwdA,
    output logic [pipePkg::fwdWidth-1:0]     FwdB
);

    logic exLive;

    // The EX instruction's result sits in the EX/WB register one cycle later.
    assign exLive = ExRegWrite && (ExWriteReg != '0);

    assign FwdA = (exLive && (Rs == ExWriteReg)) ? pipePkg::fwdWb : pipePkg::fwdNone;
    assign FwdB = (exLive && (Rt == ExWriteReg)) ? pipePkg::fwdWb : pipePkg::fwdNone;

endmodule

/* rtl/regFile.sv */
`timescale 1ns/1ps

module regFile (
    input  logic                             Clk,
    input  logic                             Reset,
    input  logic [pipePkg::regAddrWidth-1:0] RdAddrA,
    input  logic [pipePkg::regAddrWidth-1:0] RdAddrB,
    output logic [pipePkg::dataWidth-1:0]    QA,
    output logic [pipePkg::dataWidth-1:0]    QB,
    input  logic                             WrEn,
    input  logic [pipePkg::regAddrWidth-1:0] WrAddr,
    input  logic [pipePkg::dataWidth-1:0]    WrData
);

    logic [pipePkg::dataWidth-1:0] regs [0:(1 << pipePkg::regAddrWidth)-1];
    logic                          wrLive;

    // Register zero is never written, so it reads back as zero.
    assign wrLive = WrEn && (WrAddr != '0);

    always_ff @(posedge Clk or negedge Reset) begin
        if (!Reset) begin
            for (int i = 0; i < (1 << pipePkg::regAddrWidth); i++) begin
                regs[i] <= '0;
            end
        end else if (wrLive) begin
            regs[WrAddr] <= WrData;
        end
    end

    // A write in the same cycle reaches the readers before the edge.
    assign QA = (wrLive && (WrAddr == RdAddrA)) ? WrData : regs[RdAddrA];
    assign QB = (wrLive && (WrAddr == RdAddrB)) ? WrData : regs[RdAddrB];

endmodule

/* rtl/instrDecode.sv */
`timescale 1ns/1ps

module instrDecode (
    input  logic [pipePkg::dataWidth-1:0]    Instr,
    output logic [pipePkg::regAddrWidth-1:0] Rs,
    output logic [pipePkg::regAddrWidth-1:0] Rt,
    output logic [pipePkg::regAddrWidth-1:0] WriteReg,
    output logic [pipePkg::dataWidth-1:0]    Sa,
    output logic [pipePkg::dataWidth-1:0]    Imm32,
    output logic [pipePkg::aluOpWidth-1:0]   AluControl,
    output logic                             AluXSrc,
    output logic                             AluYSrc,
    output logic                             Unsigned,
    output logic                             RegWrite
);

    logic [pipePkg::opWidth-1:0] opcode;
    logic [pipePkg::opWidth-1:0] funct;
    logic [15:0]                 imm;
    logic                        signExt;
    logic                        rdDst;

    assign opcode = Instr[31:26];
    assign funct  = Instr[5:0];
    assign imm    = Instr[15:0];
    assign Rs     = Instr[25:21];
    assign Rt     = Instr[20:16];
    assign Sa     = {{(pipePkg::dataWidth-5){1'b0}}, Instr[10:6]};

    assign WriteReg = rdDst ? Instr[15:11] : Instr[20:16];
    assign Imm32    = signExt ? {{(pipePkg::dataWidth-16){imm[15]}}, imm}
                              : {{(pipePkg::dataWidth-16){1'b0}}, imm};

    always_comb begin
        AluControl = pipePkg::aluAdd;
        AluXSrc    = 1'b0;
        AluYSrc    = 1'b0;
        Unsigned   = 1'b0;
        RegWrite   = 1'b1;
        signExt    = 1'b1;
        rdDst      = 1'b0;
        if (opcode == pipePkg::opRType) begin
            rdDst = 1'b1;
            case (funct)
                pipePkg::fnAdd:  AluControl = pipePkg::aluAdd;
                pipePkg::fnSub:  AluControl = pipePkg::aluSub;
                pipePkg::fnAnd:  AluControl = pipePkg::aluAnd;
                pipePkg::fnOr:   AluControl = pipePkg::aluOr;
                pipePkg::fnXor:  AluControl = pipePkg::aluXor;
                pipePkg::fnNor:  AluControl = pipePkg::aluNor;
                pipePkg::fnSlt:  AluControl = pipePkg::aluSlt;
                pipePkg::fnAddu: Unsigned = 1'b1; // Add with no overflow check.
                pipePkg::fnSubu: begin
                    AluControl = pipePkg::aluSub;
                    Unsigned   = 1'b1;
                end
                pipePkg::fnSltu: begin
                    AluControl = pipePkg::aluSltu;
                    Unsigned   = 1'b1;
                end
                pipePkg::fnSll: begin
                    AluControl = pipePkg::aluSll;
                    AluXSrc    = 1'b1;
                end
                pipePkg::fnSrl: begin
                    AluControl = pipePkg::aluSrl;
                    AluXSrc    = 1'b1;
                end
                pipePkg::fnSra: begin
                    AluControl = pipePkg::aluSra;
                    AluXSrc    = 1'b1;
                end
                default: RegWrite = 1'b0;
            endcase
        end else begin
            AluYSrc = 1'b1;
            case (opcode)
                pipePkg::opAddi:  AluControl = pipePkg::aluAdd;
                pipePkg::opAddiu: Unsigned = 1'b1;
                pipePkg::opSlti:  AluControl = pipePkg::aluSlt;
                pipePkg::opSltiu: begin
                    AluControl = pipePkg::aluSltu; // Immediate still sign-extended.
                    Unsigned   = 1'b1;
                end
                pipePkg::opAndi: begin
                    AluControl = pipePkg::aluAnd;
                    signExt    = 1'b0;
                end
                pipePkg::opOri: begin
                    AluControl = pipePkg::aluOr;
                    signExt    = 1'b0;
                end
                pipePkg::opXori: begin
                    AluControl = pipePkg::aluXor;
                    signExt    = 1'b0;
                end
                pipePkg::opLui: begin
                    AluControl = pipePkg::aluLui;
                    signExt    = 1'b0;
                end
                default: RegWrite = 1'b0;
            endcase
        end
    end

endmodule

/* rtl/pipePkg.sv */
package pipePkg;

    localparam int dataWidth    = 32;
    localparam int regAddrWidth = 5;
    localparam int aluOpWidth   = 4;
    localparam int fwdWidth     = 3;
    localparam int opWidth      = 6;

    // ALU operation codes carried from decode to execute.
    localparam logic [aluOpWidth-1:0] aluAdd  = 4'd0;
    localparam logic [aluOpWidth-1:0] aluSub  = 4'd1;
    localparam logic [aluOpWidth-1:0] aluAnd  = 4'd2;
    localparam logic [aluOpWidth-1:0] aluOr   = 4'd3;
    localparam logic [aluOpWidth-1:0] aluXor  = 4'd4;
    localparam logic [aluOpWidth-1:0] aluNor  = 4'd5;
    localparam logic [aluOpWidth-1:0] aluSlt  = 4'd6;
    localparam logic [aluOpWidth-1:0] aluSltu = 4'd7;
    localparam logic [aluOpWidth-1:0] aluSll  = 4'd8;
    localparam logic [aluOpWidth-1:0] aluSrl  = 4'd9;
    localparam logic [aluOpWidth-1:0] aluSra  = 4'd10;
    localparam logic [aluOpWidth-1:0] aluLui  = 4'd11;

    localparam logic [opWidth-1:0] opRType = 6'h00;
    localparam logic [opWidth-1:0] opAddi  = 6'h08;
    localparam logic [opWidth-1:0] opAddiu = 6'h09;
    localparam logic [opWidth-1:0] opSlti  = 6'h0a;
    localparam logic [opWidth-1:0] opSltiu = 6'h0b;
    localparam logic [opWidth-1:0] opAndi  = 6'h0c;
    localparam logic [opWidth-1:0] opOri   = 6'h0d;
    localparam logic [opWidth-1:0] opXori  = 6'h0e;
    localparam logic [opWidth-1:0] opLui   = 6'h0f;

    // Function field of R-type instructions.
    localparam logic [opWidth-1:0] fnSll  = 6'h00;
    localparam logic [opWidth-1:0] fnSrl  = 6'h02;
    localparam logic [opWidth-1:0] fnSra  = 6'h03;
    localparam logic [opWidth-1:0] fnAdd  = 6'h20;
    localparam logic [opWidth-1:0] fnAddu = 6'h21;
    localparam logic [opWidth-1:0] fnSub  = 6'h22;
    localparam logic [opWidth-1:0] fnSubu = 6'h23;
    localparam logic [opWidth-1:0] fnAnd  = 6'h24;
    localparam logic [opWidth-1:0] fnOr   = 6'h25;
    localparam logic [opWidth-1:0] fnXor  = 6'h26;
    localparam logic [opWidth-1:0] fnNor  = 6'h27;
    localparam logic [opWidth-1:0] fnSlt  = 6'h2a;
    localparam logic [opWidth-1:0] fnSltu = 6'h2b;

    localparam logic [fwdWidth-1:0] fwdNone = 3'd0; // Register file value.
    localparam logic [fwdWidth-1:0] fwdWb   = 3'd1; // EX/WB result register.

endpackage
